// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_frame_decoder
FILELIST  ?= frame_decoder.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= NO ERRORS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== frame_assembler.sv ====
`timescale 1ns/100ps

module frame_assembler (
    input  logic                     glb_clk,
    input  logic                     glb_areset_n,
    input  logic                     hdr_valid,
    input  frame_decoder_pkg::word_t addr_w0,
    input  frame_decoder_pkg::word_t addr_w1,
    input  frame_decoder_pkg::word_t addr_w2,
    input  frame_decoder_pkg::ecn_t  ecn_out,
    input  logic                     buf_valid,
    input  frame_decoder_pkg::word_t buf_data,
    input  frame_decoder_pkg::keep_t buf_keep,
    input  logic                     buf_last,
    input  logic                     m_axis_tready,
    output logic                     m_axis_tvalid,
    output frame_decoder_pkg::word_t m_axis_tdata,
    output frame_decoder_pkg::keep_t m_axis_tkeep,
    output logic                     m_axis_tlast,
    output logic                     buf_pop,
    output logic                     frame_done
);

    frame_decoder_pkg::asm_state_t state;
    frame_decoder_pkg::asm_state_t state_next;
    logic [1:0]                    addr_idx;

    logic                          load_en;
    logic                          word_avail;
    frame_decoder_pkg::word_t      word_data;
    frame_decoder_pkg::keep_t      word_keep;
    logic                          word_last;

    // output register takes a new word when empty or draining
    assign load_en    = !m_axis_tvalid || m_axis_tready;
    assign frame_done = m_axis_tvalid && m_axis_tready && m_axis_tlast;

    // --------------------
    // next word select
    always_comb
    begin
        state_next = state;
        word_avail = 1'b0;
        word_data  = buf_data;
        word_keep  = buf_keep;
        word_last  = buf_last;
        case (state)
            frame_decoder_pkg::WAIT_FRAME:
            begin
                // old frame's last word must be gone first
                if (hdr_valid && !m_axis_tvalid)
                    state_next = frame_decoder_pkg::SEND_ADDR;
            end
            frame_decoder_pkg::SEND_ADDR:
            begin
                word_avail = 1'b1;
                word_keep  = 4'hf;
                word_last  = 1'b0;
                case (addr_idx)
                    2'd0:    word_data = addr_w0;
                    2'd1:    word_data = addr_w1;
                    default: word_data = addr_w2;
                endcase
                if (load_en && addr_idx == 2'd2)
                    state_next = frame_decoder_pkg::SEND_LT;
            end
            frame_decoder_pkg::SEND_LT:
            begin
                word_avail = buf_valid;
                word_data  = {buf_data[31:24], ecn_out, buf_data[15:0]};
                if (load_en && buf_valid)
                    state_next = buf_last ? frame_decoder_pkg::WAIT_FRAME
                                          : frame_decoder_pkg::SEND_PAYLOAD;
            end
            default:
            begin
                word_avail = buf_valid;
                if (load_en && buf_valid && buf_last)
                    state_next = frame_decoder_pkg::WAIT_FRAME;
            end
        endcase
    end

    assign buf_pop = load_en && word_avail
        && (state == frame_decoder_pkg::SEND_LT || state == frame_decoder_pkg::SEND_PAYLOAD);

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            state         <= frame_decoder_pkg::WAIT_FRAME;
            addr_idx      <= 2'd0;
            m_axis_tvalid <= 1'b0;
            m_axis_tlast  <= 1'b0;
        end
        else
        begin
            state <= state_next;
            if (state == frame_decoder_pkg::SEND_ADDR && load_en)
                addr_idx <= (addr_idx == 2'd2) ? 2'd0 : addr_idx + 1'b1;
            if (load_en)
            begin
                m_axis_tvalid <= word_avail;
                if (word_avail)
                    m_axis_tlast <= word_last;
            end
        end
    end

    always_ff @(posedge glb_clk)
    begin
        if (load_en && word_avail)
        begin
            m_axis_tdata <= word_data;
            m_axis_tkeep <= word_keep;
        end
    end

    a_hold_on_stall: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tkeep)
            && $stable(m_axis_tlast)
    );

endmodule

// ==== frame_decoder.f ====
frame_decoder_pkg.sv
frame_header_parser.sv
payload_realign.sv
frame_assembler.sv
frame_decoder.sv
tb_clock_gen.sv
tb_frame_checker.sv
tb_frame_decoder.sv

// ==== frame_decoder.sv ====
`timescale 1ns/100ps

module frame_decoder (
    input  logic                           glb_clk,
    input  logic                           glb_areset_n,

    input  logic                           s_axis_tvalid,
    output logic                           s_axis_tready,
    input  frame_decoder_pkg::word_t       s_axis_tdata,
    input  frame_decoder_pkg::keep_t       s_axis_tkeep,
    input  logic                           s_axis_tlast,

    output logic                           m_axis_tvalid,
    input  logic                           m_axis_tready,
    output frame_decoder_pkg::word_t       m_axis_tdata,
    output frame_decoder_pkg::keep_t       m_axis_tkeep,
    output logic                           m_axis_tlast,

    output frame_decoder_pkg::port_sel_t   bus_sel,

    input  frame_decoder_pkg::fifo_level_t fifo_0_space_used,
    input  frame_decoder_pkg::fifo_level_t fifo_1_space_used
);

    logic                     beat_accept;
    logic                     lt_beat;
    logic                     hdr_valid;
    logic                     frame_done;
    frame_decoder_pkg::word_t addr_w0;
    frame_decoder_pkg::word_t addr_w1;
    frame_decoder_pkg::word_t addr_w2;
    frame_decoder_pkg::ecn_t  ecn_out;

    logic                     buf_valid;
    frame_decoder_pkg::word_t buf_data;
    frame_decoder_pkg::keep_t buf_keep;
    logic                     buf_last;
    logic                     buf_pop;

    // --------------------
    // header and payload paths
    frame_header_parser u_parser (
        .glb_clk           (glb_clk),
        .glb_areset_n      (glb_areset_n),
        .beat_accept       (beat_accept),
        .s_axis_tdata      (s_axis_tdata),
        .s_axis_tlast      (s_axis_tlast),
        .fifo_0_space_used (fifo_0_space_used),
        .fifo_1_space_used (fifo_1_space_used),
        .frame_done        (frame_done),
        .lt_beat           (lt_beat),
        .hdr_valid         (hdr_valid),
        .addr_w0           (addr_w0),
        .addr_w1           (addr_w1),
        .addr_w2           (addr_w2),
        .ecn_out           (ecn_out),
        .bus_sel           (bus_sel)
    );

    payload_realign u_realign (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tlast  (s_axis_tlast),
        .lt_beat       (lt_beat),
        .buf_pop       (buf_pop),
        .frame_done    (frame_done),
        .s_axis_tready (s_axis_tready),
        .beat_accept   (beat_accept),
        .buf_valid     (buf_valid),
        .buf_data      (buf_data),
        .buf_keep      (buf_keep),
        .buf_last      (buf_last)
    );

    // output side
    frame_assembler u_assembler (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .hdr_valid     (hdr_valid),
        .addr_w0       (addr_w0),
        .addr_w1       (addr_w1),
        .addr_w2       (addr_w2),
        .ecn_out       (ecn_out),
        .buf_valid     (buf_valid),
        .buf_data      (buf_data),
        .buf_keep      (buf_keep),
        .buf_last      (buf_last),
        .m_axis_tready (m_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .buf_pop       (buf_pop),
        .frame_done    (frame_done)
    );

endmodule

// ==== frame_decoder_pkg.sv ====
package frame_decoder_pkg;

    // --------------------
    // sizes
    localparam int PORT_NUM      = 2;
    localparam int WORD_BYTES    = 4;
    localparam int HDR_WORDS     = 4;
    localparam int PAYLOAD_DEPTH = 4;

    localparam int BUF_PTR_W = $clog2(PAYLOAD_DEPTH);
    localparam int BUF_CNT_W = BUF_PTR_W + 1;
    localparam int HDR_CNT_W = $clog2(HDR_WORDS + 1);

    // --------------------
    // field types
    typedef logic [WORD_BYTES*8-1:0] word_t;
    typedef logic [WORD_BYTES-1:0]   keep_t;
    typedef logic [47:0]             mac_t;
    typedef logic [15:0]             len_type_t;
    typedef logic [7:0]              ecn_t;
    typedef logic [7:0]              label_t;
    typedef logic [31:0]             fifo_level_t;
    typedef logic [PORT_NUM-1:0]     port_sel_t;

    typedef logic [BUF_PTR_W-1:0]    buf_ptr_t;
    typedef logic [BUF_CNT_W-1:0]    buf_cnt_t;
    typedef logic [HDR_CNT_W-1:0]    hdr_cnt_t;

    // --------------------
    // labels and congestion
    localparam label_t      LABEL_BASE           = 8'd1;
    localparam label_t      LABEL_END            = 8'hff;
    localparam label_t      LABEL_NONE           = 8'hfe;
    localparam fifo_level_t FIFO_ALERT_THRESHOLD = 32'd3000;
    localparam ecn_t        ECN_MARK             = 8'd1;

    // output side of the frame
    typedef enum logic [1:0] {
        SEND_ADDR,
        SEND_LT,
        SEND_PAYLOAD,
        WAIT_FRAME
    } asm_state_t;

endpackage

// ==== frame_header_parser.sv ====
`timescale 1ns/100ps

module frame_header_parser (
    input  logic                           glb_clk,
    input  logic                           glb_areset_n,
    input  logic                           beat_accept,
    input  frame_decoder_pkg::word_t       s_axis_tdata,
    input  logic                           s_axis_tlast,
    input  frame_decoder_pkg::fifo_level_t fifo_0_space_used,
    input  frame_decoder_pkg::fifo_level_t fifo_1_space_used,
    input  logic                           frame_done,
    output logic                           lt_beat,
    output logic                           hdr_valid,
    output frame_decoder_pkg::word_t       addr_w0,
    output frame_decoder_pkg::word_t       addr_w1,
    output frame_decoder_pkg::word_t       addr_w2,
    output frame_decoder_pkg::ecn_t        ecn_out,
    output frame_decoder_pkg::port_sel_t   bus_sel
);

    frame_decoder_pkg::hdr_cnt_t  beat_cnt;
    frame_decoder_pkg::label_t    label;
    frame_decoder_pkg::port_sel_t sel_next;
    frame_decoder_pkg::port_sel_t over_thr;
    frame_decoder_pkg::ecn_t      ecn_next;
    logic                         no_port;

    assign lt_beat = beat_accept
        && (beat_cnt == frame_decoder_pkg::hdr_cnt_t'(frame_decoder_pkg::HDR_WORDS - 1));

    // header beat counter, saturates once the label word is past
    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            beat_cnt <= '0;
        end
        else if (beat_accept)
        begin
            if (s_axis_tlast)
                beat_cnt <= '0;
            else if (beat_cnt != frame_decoder_pkg::hdr_cnt_t'(frame_decoder_pkg::HDR_WORDS))
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // --------------------
    // route decode on the label word
    always_comb
    begin
        label   = s_axis_tdata[31:24];
        no_port = (label == frame_decoder_pkg::LABEL_END)
               || (label == frame_decoder_pkg::LABEL_NONE);
        sel_next = '0;
        for (int p = 0; p < frame_decoder_pkg::PORT_NUM; p++)
        begin
            if (!no_port && label == frame_decoder_pkg::label_t'(frame_decoder_pkg::LABEL_BASE + p))
                sel_next[p] = 1'b1;
        end
        over_thr = {fifo_1_space_used > frame_decoder_pkg::FIFO_ALERT_THRESHOLD,
                    fifo_0_space_used > frame_decoder_pkg::FIFO_ALERT_THRESHOLD};
        // only the chosen port's level counts
        ecn_next = (|(sel_next & over_thr)) ? frame_decoder_pkg::ECN_MARK : s_axis_tdata[23:16];
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            hdr_valid <= 1'b0;
            bus_sel   <= '0;
        end
        else if (frame_done)
        begin
            hdr_valid <= 1'b0;
            bus_sel   <= '0;
        end
        else if (lt_beat)
        begin
            hdr_valid <= 1'b1;
            bus_sel   <= sel_next;
        end
    end

    // address words and ecn
    always_ff @(posedge glb_clk)
    begin
        if (beat_accept)
        begin
            if (beat_cnt == frame_decoder_pkg::hdr_cnt_t'(0))
                addr_w0 <= s_axis_tdata;
            if (beat_cnt == frame_decoder_pkg::hdr_cnt_t'(1))
                addr_w1 <= s_axis_tdata;
            if (beat_cnt == frame_decoder_pkg::hdr_cnt_t'(2))
                addr_w2 <= s_axis_tdata;
        end
        if (lt_beat)
            ecn_out <= ecn_next;
    end

    a_bus_sel_onehot0: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        $onehot0(bus_sel)
    );

endmodule

// ==== payload_realign.sv ====
`timescale 1ns/100ps

module payload_realign (
    input  logic                     glb_clk,
    input  logic                     glb_areset_n,
    input  logic                     s_axis_tvalid,
    input  frame_decoder_pkg::word_t s_axis_tdata,
    input  frame_decoder_pkg::keep_t s_axis_tkeep,
    input  logic                     s_axis_tlast,
    input  logic                     lt_beat,
    input  logic                     buf_pop,
    input  logic                     frame_done,
    output logic                     s_axis_tready,
    output logic                     beat_accept,
    output logic                     buf_valid,
    output frame_decoder_pkg::word_t buf_data,
    output frame_decoder_pkg::keep_t buf_keep,
    output logic                     buf_last
);

    frame_decoder_pkg::word_t mem_data [frame_decoder_pkg::PAYLOAD_DEPTH];
    frame_decoder_pkg::keep_t mem_keep [frame_decoder_pkg::PAYLOAD_DEPTH];
    logic                     mem_last [frame_decoder_pkg::PAYLOAD_DEPTH];

    frame_decoder_pkg::buf_ptr_t wr_ptr;
    frame_decoder_pkg::buf_ptr_t rd_ptr;
    frame_decoder_pkg::buf_cnt_t buf_count;
    logic                        buf_full;

    logic                        in_open;
    logic                        in_payload;
    logic                        flush_pend;
    logic [23:0]                 carry;
    frame_decoder_pkg::keep_t    carry_keep;

    logic                        push_en;
    frame_decoder_pkg::word_t    push_data;
    frame_decoder_pkg::keep_t    push_keep;
    logic                        push_last;

    assign buf_full      = (buf_count == frame_decoder_pkg::buf_cnt_t'(frame_decoder_pkg::PAYLOAD_DEPTH));
    assign s_axis_tready = s_axis_tvalid && in_open && !buf_full;
    assign beat_accept   = s_axis_tvalid && s_axis_tready;

    // input closes after the last beat until the frame has left
    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
            in_open <= 1'b1;
        else if (beat_accept && s_axis_tlast)
            in_open <= 1'b0;
        else if (frame_done)
            in_open <= 1'b1;
    end

    // --------------------
    // byte repack
    always_comb
    begin
        push_en   = (beat_accept && in_payload) || (flush_pend && !buf_full);
        push_data = flush_pend ? {8'h00, carry} : {s_axis_tdata[7:0], carry};
        push_keep = flush_pend ? carry_keep : 4'hf;
        push_last = flush_pend || (s_axis_tlast && s_axis_tkeep == 4'h1);
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            in_payload <= 1'b0;
            flush_pend <= 1'b0;
        end
        else
        begin
            if (flush_pend && !buf_full)
                flush_pend <= 1'b0;
            if (beat_accept && lt_beat)
            begin
                in_payload <= !s_axis_tlast;
                flush_pend <= s_axis_tlast;
            end
            else if (beat_accept && in_payload && s_axis_tlast)
            begin
                in_payload <= 1'b0;
                flush_pend <= (s_axis_tkeep != 4'h1);
            end
        end
    end

    // lt and ecn bytes are carried, the label byte is dropped
    always_ff @(posedge glb_clk)
    begin
        if (beat_accept && lt_beat)
        begin
            carry      <= s_axis_tdata[23:0];
            carry_keep <= {1'b0, s_axis_tkeep[2:0]};
        end
        else if (beat_accept && in_payload)
        begin
            carry      <= s_axis_tdata[31:8];
            carry_keep <= {1'b0, s_axis_tkeep[3:1]};
        end
    end

    // --------------------
    // word buffer
    always_ff @(posedge glb_clk)
    begin
        if (push_en)
        begin
            mem_data[wr_ptr] <= push_data;
            mem_keep[wr_ptr] <= push_keep;
            mem_last[wr_ptr] <= push_last;
        end
    end

    always_ff @(posedge glb_clk or negedge glb_areset_n)
    begin
        if (!glb_areset_n)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            buf_count <= '0;
        end
        else
        begin
            if (push_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (buf_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push_en && !buf_pop)
                buf_count <= buf_count + 1'b1;
            else if (buf_pop && !push_en)
                buf_count <= buf_count - 1'b1;
        end
    end

    assign buf_valid = (buf_count != '0);
    assign buf_data  = mem_data[rd_ptr];
    assign buf_keep  = mem_keep[rd_ptr];
    assign buf_last  = mem_last[rd_ptr];

    a_no_push_full: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        buf_full |-> !(push_en && !buf_pop)
    );

    a_no_pop_empty: assert property (
        @(posedge glb_clk) disable iff (!glb_areset_n)
        buf_pop |-> buf_valid
    );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 4
) (
    output logic glb_clk,
    output logic glb_areset_n
);

    initial
    begin
        glb_clk = 1'b0;
        forever
        begin
            #(HALF_PERIOD);
            glb_clk = ~glb_clk;
        end
    end

    // release on a falling edge, clear of the capture edge
    initial
    begin
        glb_areset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge glb_clk);
        @(negedge glb_clk);
        glb_areset_n = 1'b1;
    end

endmodule

// ==== tb_frame_checker.sv ====
`timescale 1ns/100ps

module tb_frame_checker #(
    parameter int MAX_BYTES = 48
) (
    input  logic                         glb_clk,
    input  logic                         glb_areset_n,
    input  logic                         s_axis_tready,
    input  logic                         m_axis_tvalid,
    input  logic                         m_axis_tready,
    input  frame_decoder_pkg::word_t     m_axis_tdata,
    input  frame_decoder_pkg::keep_t     m_axis_tkeep,
    input  logic                         m_axis_tlast,
    input  frame_decoder_pkg::port_sel_t bus_sel,
    output int                           pass_count,
    output int                           fail_count,
    output int                           frame_count
);

    // filled by the driver only, read here by index
    logic [7:0]                   exp_bytes [$];
    int                           exp_len   [$];
    frame_decoder_pkg::port_sel_t exp_sel   [$];

    int   frame_base;
    int   got_bytes;
    logic frame_bad;
    logic sel_bad;
    logic reset_checked;

    // --------------------
    // expected frame from the input bytes
    task automatic expect_frame(input logic [8*MAX_BYTES-1:0] frame, input int n_bytes,
                                input frame_decoder_pkg::fifo_level_t lvl0,
                                input frame_decoder_pkg::fifo_level_t lvl1);
        frame_decoder_pkg::label_t    label;
        frame_decoder_pkg::port_sel_t sel;
        int                           port;
        logic                         mark;
        logic [7:0]                   b;

        label = frame[8*15 +: 8];
        port  = int'(label) - int'(frame_decoder_pkg::LABEL_BASE);
        sel   = '0;
        if (port >= 0 && port < frame_decoder_pkg::PORT_NUM)
            sel = frame_decoder_pkg::port_sel_t'(1) << port;
        mark = (sel[0] && lvl0 > frame_decoder_pkg::FIFO_ALERT_THRESHOLD)
            || (sel[1] && lvl1 > frame_decoder_pkg::FIFO_ALERT_THRESHOLD);
        // label byte goes, ecn byte keeps its place
        for (int i = 0; i < n_bytes; i++)
        begin
            b = frame[8*i +: 8];
            if (i == 14 && mark)
                b = frame_decoder_pkg::ECN_MARK;
            if (i != 15)
                exp_bytes.push_back(b);
        end
        exp_len.push_back(n_bytes - 1);
        exp_sel.push_back(sel);
    endtask

    task automatic report_error(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        frame_bad = 1'b1;
    endtask

    task automatic check_idle();
        reset_checked = 1'b1;
        if (m_axis_tvalid !== 1'b0 || s_axis_tready !== 1'b0 || bus_sel !== '0)
        begin
            $display("** Error at %0t: not idle after reset, tvalid %b tready %b bus_sel %b",
                     $time, m_axis_tvalid, s_axis_tready, bus_sel);
            fail_count++;
            $display("test reset state: FAILED");
        end
        else
        begin
            pass_count++;
            $display("test reset state: passed");
        end
    endtask

    task automatic check_route();
        if (frame_count >= exp_sel.size())
            report_error("output word with no frame expected");
        else if (bus_sel !== exp_sel[frame_count] && !sel_bad)
        begin
            sel_bad = 1'b1;
            report_error($sformatf("frame %0d bus_sel expected %b got %b",
                                   frame_count, exp_sel[frame_count], bus_sel));
        end
    endtask

    task automatic check_beat();
        int idx;

        for (int k = 0; k < frame_decoder_pkg::WORD_BYTES; k++)
        begin
            if (m_axis_tkeep[k])
            begin
                idx = frame_base + got_bytes;
                if (frame_count >= exp_len.size() || got_bytes >= exp_len[frame_count])
                    report_error($sformatf("frame %0d extra output byte %0d",
                                           frame_count, got_bytes));
                else if (m_axis_tdata[8*k +: 8] !== exp_bytes[idx])
                    report_error($sformatf("frame %0d byte %0d expected %02h got %02h",
                                           frame_count, got_bytes, exp_bytes[idx],
                                           m_axis_tdata[8*k +: 8]));
                got_bytes++;
            end
        end
        if (m_axis_tlast)
            finish_frame();
    endtask

    task automatic finish_frame();
        if (frame_count < exp_len.size())
        begin
            if (got_bytes != exp_len[frame_count])
                report_error($sformatf("frame %0d has %0d bytes, expected %0d",
                                       frame_count, got_bytes, exp_len[frame_count]));
            frame_base += exp_len[frame_count];
        end
        if (frame_bad)
        begin
            fail_count++;
            $display("test frame %0d (%0d bytes out): FAILED", frame_count, got_bytes);
        end
        else
        begin
            pass_count++;
            $display("test frame %0d (%0d bytes out, bus_sel %b): passed",
                     frame_count, got_bytes, bus_sel);
        end
        frame_count++;
        got_bytes = 0;
        frame_bad = 1'b0;
        sel_bad   = 1'b0;
    endtask

    // --------------------
    // monitor, sampled on the transfer edge
    always @(posedge glb_clk)
    begin
        if (!glb_areset_n)
        begin
            pass_count    = 0;
            fail_count    = 0;
            frame_count   = 0;
            frame_base    = 0;
            got_bytes     = 0;
            frame_bad     = 1'b0;
            sel_bad       = 1'b0;
            reset_checked = 1'b0;
        end
        else
        begin
            if (!reset_checked)
                check_idle();
            if (m_axis_tvalid)
                check_route();
            if (m_axis_tvalid && m_axis_tready)
                check_beat();
        end
    end

endmodule

// ==== tb_frame_decoder.sv ====
`timescale 1ns/100ps

module tb_frame_decoder;

    localparam int NUM_ROWS  = 16;
    localparam int MAX_BYTES = 48;
    localparam int READY_LEN = 61;
    localparam int TIMEOUT   = 2000;
    localparam int SEED      = 22089;

    typedef struct packed {
        int                             n_bytes;
        frame_decoder_pkg::label_t      label;
        frame_decoder_pkg::ecn_t        ecn;
        frame_decoder_pkg::fifo_level_t lvl0;
        frame_decoder_pkg::fifo_level_t lvl1;
        logic                           rnd;
    } row_t;

    logic                           glb_clk;
    logic                           glb_areset_n;
    logic                           s_axis_tvalid;
    logic                           s_axis_tready;
    frame_decoder_pkg::word_t       s_axis_tdata;
    frame_decoder_pkg::keep_t       s_axis_tkeep;
    logic                           s_axis_tlast;
    logic                           m_axis_tvalid;
    logic                           m_axis_tready;
    frame_decoder_pkg::word_t       m_axis_tdata;
    frame_decoder_pkg::keep_t       m_axis_tkeep;
    logic                           m_axis_tlast;
    frame_decoder_pkg::port_sel_t   bus_sel;
    frame_decoder_pkg::fifo_level_t fifo_0_space_used;
    frame_decoder_pkg::fifo_level_t fifo_1_space_used;

    int   pass_count;
    int   fail_count;
    int   frame_count;
    logic rnd_mode;
    logic timed_out;
    logic ready_pat [READY_LEN];

    // bytes, label, ecn, fifo 0, fifo 1, random ready and gaps
    row_t rows [NUM_ROWS] = '{
        '{17, 8'h01, 8'h21, 32'd0,    32'd0,    1'b0},
        '{18, 8'h02, 8'h22, 32'd0,    32'd0,    1'b0},
        '{19, 8'hfe, 8'h23, 32'd4000, 32'd4000, 1'b0},
        '{20, 8'hff, 8'h24, 32'd4000, 32'd4000, 1'b0},
        '{21, 8'h07, 8'h25, 32'd4000, 32'd4000, 1'b0},
        '{22, 8'h01, 8'h26, 32'd3001, 32'd0,    1'b0},
        '{23, 8'h01, 8'h27, 32'd3000, 32'd0,    1'b0},
        '{24, 8'h02, 8'h28, 32'd9000, 32'd0,    1'b0},
        '{25, 8'h02, 8'h29, 32'd0,    32'd3001, 1'b0},
        '{26, 8'h01, 8'h2a, 32'd100,  32'd200,  1'b1},
        '{29, 8'h02, 8'h2b, 32'd0,    32'd3500, 1'b1},
        '{31, 8'h01, 8'h2c, 32'd3001, 32'd0,    1'b1},
        '{33, 8'hfe, 8'h2d, 32'd0,    32'd0,    1'b1},
        '{36, 8'h02, 8'h2e, 32'd0,    32'd0,    1'b1},
        '{38, 8'h01, 8'h2f, 32'd0,    32'd0,    1'b1},
        '{40, 8'h02, 8'h30, 32'd3000, 32'd3001, 1'b1}
    };

    tb_clock_gen u_clk (
        .glb_clk      (glb_clk),
        .glb_areset_n (glb_areset_n)
    );

    frame_decoder dut0 (
        .glb_clk           (glb_clk),
        .glb_areset_n      (glb_areset_n),
        .s_axis_tvalid     (s_axis_tvalid),
        .s_axis_tready     (s_axis_tready),
        .s_axis_tdata      (s_axis_tdata),
        .s_axis_tkeep      (s_axis_tkeep),
        .s_axis_tlast      (s_axis_tlast),
        .m_axis_tvalid     (m_axis_tvalid),
        .m_axis_tready     (m_axis_tready),
        .m_axis_tdata      (m_axis_tdata),
        .m_axis_tkeep      (m_axis_tkeep),
        .m_axis_tlast      (m_axis_tlast),
        .bus_sel           (bus_sel),
        .fifo_0_space_used (fifo_0_space_used),
        .fifo_1_space_used (fifo_1_space_used)
    );

    tb_frame_checker #(.MAX_BYTES(MAX_BYTES)) u_checker (
        .glb_clk       (glb_clk),
        .glb_areset_n  (glb_areset_n),
        .s_axis_tready (s_axis_tready),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .bus_sel       (bus_sel),
        .pass_count    (pass_count),
        .fail_count    (fail_count),
        .frame_count   (frame_count)
    );

    // --------------------
    // input driver
    task automatic send_beat(input int frame_idx, input int beat_idx,
                             input frame_decoder_pkg::word_t data,
                             input frame_decoder_pkg::keep_t keep,
                             input logic last, input logic gaps);
        int wait_cnt;

        @(negedge glb_clk);
        if (gaps && ($urandom % 3 == 0))
        begin
            s_axis_tvalid = 1'b0;
            @(negedge glb_clk);
        end
        s_axis_tvalid = 1'b1;
        s_axis_tdata  = data;
        s_axis_tkeep  = keep;
        s_axis_tlast  = last;
        wait_cnt = 0;
        @(posedge glb_clk);
        while (!s_axis_tready && wait_cnt < TIMEOUT)
        begin
            @(posedge glb_clk);
            wait_cnt++;
        end
        if (!s_axis_tready)
        begin
            $display("timeout: beat %0d of frame %0d was never accepted", beat_idx, frame_idx);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_frame(input int frame_idx, input row_t r);
        logic [8*MAX_BYTES-1:0]   bytes;
        frame_decoder_pkg::word_t data;
        frame_decoder_pkg::keep_t keep;
        int                       n_words;

        bytes = '0;
        for (int i = 0; i < r.n_bytes; i++)
            bytes[8*i +: 8] = 8'($urandom);
        bytes[8*14 +: 8] = r.ecn;
        bytes[8*15 +: 8] = r.label;
        u_checker.expect_frame(bytes, r.n_bytes, r.lvl0, r.lvl1);

        @(negedge glb_clk);
        fifo_0_space_used = r.lvl0;
        fifo_1_space_used = r.lvl1;
        rnd_mode          = r.rnd;
        n_words = (r.n_bytes + 3) / 4;
        for (int w = 0; w < n_words && !timed_out; w++)
        begin
            data = '0;
            keep = '0;
            for (int k = 0; k < frame_decoder_pkg::WORD_BYTES; k++)
            begin
                if (4*w + k < r.n_bytes)
                begin
                    data[8*k +: 8] = bytes[8*(4*w + k) +: 8];
                    keep[k] = 1'b1;
                end
            end
            send_beat(frame_idx, w, data, keep, w == n_words - 1, r.rnd);
        end
        @(negedge glb_clk);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    // output ready, cycles through a random pattern in random rows
    initial
    begin
        int pat_idx;

        pat_idx = 0;
        m_axis_tready = 1'b1;
        forever
        begin
            @(negedge glb_clk);
            if (rnd_mode)
            begin
                m_axis_tready = ready_pat[pat_idx];
                pat_idx = (pat_idx + 1) % READY_LEN;
            end
            else
                m_axis_tready = 1'b1;
        end
    end

    // --------------------
    // main sequence
    initial
    begin
        int wait_cnt;

        s_axis_tvalid     = 1'b0;
        s_axis_tdata      = '0;
        s_axis_tkeep      = '0;
        s_axis_tlast      = 1'b0;
        fifo_0_space_used = '0;
        fifo_1_space_used = '0;
        rnd_mode          = 1'b0;
        timed_out         = 1'b0;
        void'($urandom(SEED));
        for (int i = 0; i < READY_LEN; i++)
            ready_pat[i] = ($urandom % 4) != 0;

        wait_cnt = 0;
        while (glb_areset_n !== 1'b1 && wait_cnt < TIMEOUT)
        begin
            @(negedge glb_clk);
            wait_cnt++;
        end
        if (glb_areset_n !== 1'b1)
        begin
            $display("timeout: reset was never released");
            timed_out = 1'b1;
        end
        // idle so the reset state can be seen
        repeat (2) @(negedge glb_clk);

        for (int i = 0; i < NUM_ROWS && !timed_out; i++)
            send_frame(i, rows[i]);

        wait_cnt = 0;
        while (!timed_out && frame_count < NUM_ROWS && wait_cnt < TIMEOUT)
        begin
            @(negedge glb_clk);
            wait_cnt++;
        end
        if (!timed_out && frame_count < NUM_ROWS)
        begin
            $display("timeout: only %0d of %0d frames came out", frame_count, NUM_ROWS);
            timed_out = 1'b1;
        end
        repeat (4) @(negedge glb_clk);

        $display("tests passed %0d, failed %0d, frames out %0d of %0d",
                 pass_count, fail_count, frame_count, NUM_ROWS);
        if (!timed_out && fail_count == 0 && frame_count == NUM_ROWS
            && pass_count == NUM_ROWS + 1)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule
